// ==== rtl/cent_defines.svh ====
// centipede i/o board constants
// bus widths, earom depth and the region codes found on address bits 13..10

`ifndef CENT_DEFINES_SVH
`define CENT_DEFINES_SVH

// internal address bus, the old 6502 map only needs 14 bits
`define CENT_ADDR_W 14

// every register on the board is one byte
`define CENT_DATA_W 8

// 64 byte high score earom
`define CENT_EAROM_AW 6

// region codes on ab[13:10]
// option switch banks, 0x0800
`define CENT_BLK_SW 2

// in0 at 0x0c00, in1 at 0x0c02, ab[1] picks in1
`define CENT_BLK_IN 3

// earom block, also needs ab[9] high
// ab[8:7] = 0 read, 1 control, 2 address/data
`define CENT_BLK_EA 5

// output latch, 0x1c00..0x1c07
`define CENT_BLK_OUT 7

`endif

// ==== rtl/cent_bus_pkg.sv ====
// bus types for the centipede i/o block
// axi4-lite channel payloads and the internal single beat request

`include "cent_defines.svh"

package cent_bus_pkg;

	// only okay is ever returned
	localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

	// write address channel payload
	typedef struct packed {
		logic [`CENT_ADDR_W-1:0] addr;
	} axil_aw_t;

	// write data channel payload, no strobes since every register is a byte
	typedef struct packed {
		logic [`CENT_DATA_W-1:0] data;
	} axil_w_t;

	// read address channel payload
	typedef struct packed {
		logic [`CENT_ADDR_W-1:0] addr;
	} axil_ar_t;

	// read data channel payload
	typedef struct packed {
		logic [1:0]              resp;
		logic [`CENT_DATA_W-1:0] data;
	} axil_r_t;

	// internal request, valid for exactly one cycle per transaction
	// 1 + 1 + 14 + 8 = 24 bits
	typedef struct packed {
		logic                    valid;
		logic                    write;
		logic [`CENT_ADDR_W-1:0] addr;
		logic [`CENT_DATA_W-1:0] wdata;
	} bus_req_t;

endpackage

// ==== rtl/cent_io_pkg.sv ====
// i/o types for the centipede board
// region code plus the player, trackball and output latch bundles

package cent_io_pkg;

	// decoded i/o region
	typedef enum logic [2:0] {
		REG_NONE,
		REG_SW,
		REG_IN0,
		REG_IN1,
		REG_EA_RD,
		REG_EA_CTRL,
		REG_EA_ADDR,
		REG_OUT
	} io_region_e;

	// player controls, same bit order as the cabinet harness
	typedef struct packed {
		logic coin_r;
		logic coin_c;
		logic coin_l;
		logic self_test;
		logic cocktail;
		logic slam;
		logic start2;
		logic start1;
		logic fire2;
		logic fire1;
	} player_in_t;

	// raw mini-trackball lines for both players
	typedef struct packed {
		logic p1_h_dir;
		logic p2_h_dir;
		logic p1_h_ck;
		logic p2_h_ck;
		logic p1_v_dir;
		logic p2_v_dir;
		logic p1_v_ck;
		logic p2_v_ck;
	} trak_t;

	// counter state as seen by the read mux
	typedef struct packed {
		logic       h_dir;
		logic       v_dir;
		logic [3:0] h_cnt;
		logic [3:0] v_cnt;
	} trak_state_t;

	// output latch bits, msb first as addressed by ab[2:0]
	typedef struct packed {
		logic       flip;
		logic [4:1] lamp;
		logic       coin_ctr_r;
		logic       coin_ctr_c;
		logic       coin_ctr_l;
	} latch_out_t;

endpackage

// ==== rtl/axil_bus_slave.sv ====
// axi4-lite slave for the i/o board
// keeps one transaction in flight as a single cycle internal request
// read data comes back from the router two cycles after the ar handshake

`include "cent_defines.svh"

module axil_bus_slave
	import cent_bus_pkg::*;
(
	input  logic                    s_6mhz_i,
	input  logic                    reset,
	input  axil_aw_t                aw_i,
	input  logic                    awvalid_i,
	output logic                    awready_o,
	input  axil_w_t                 w_i,
	input  logic                    wvalid_i,
	output logic                    wready_o,
	output logic                    bvalid_o,
	input  logic                    bready_i,
	input  axil_ar_t                ar_i,
	input  logic                    arvalid_i,
	output logic                    arready_o,
	output logic                    rvalid_o,
	output axil_r_t                 r_o,
	input  logic                    rready_i,
	input  logic [`CENT_DATA_W-1:0] rdata_i,
	output bus_req_t                req_o
);

	logic                    aw_go;
	logic                    ar_hs;
	logic                    rd_req;
	logic                    arready_q;
	logic                    bvalid_q;
	logic                    rvalid_q;
	logic                    rd_first_q;
	logic                    req_valid_q;
	logic                    req_write_q;
	logic [`CENT_ADDR_W-1:0] req_addr_q;
	logic [`CENT_DATA_W-1:0] req_wdata_q;
	logic [`CENT_DATA_W-1:0] r_data_q;

	// arready_q doubles as the idle flag
	// write wins only when both channels show up in the same cycle
	assign aw_go  = awvalid_i & wvalid_i & arready_q;
	assign ar_hs  = arvalid_i & arready_q & ~aw_go;
	assign rd_req = req_valid_q & ~req_write_q;

	assign awready_o = aw_go;
	assign wready_o  = aw_go;
	assign arready_o = arready_q & ~aw_go;
	assign bvalid_o  = bvalid_q;
	assign rvalid_o  = rvalid_q;

	assign req_o = '{valid: req_valid_q, write: req_write_q,
		addr: req_addr_q, wdata: req_wdata_q};

	// first rvalid cycle passes the router byte through, then the held copy
	assign r_o = '{resp: AXIL_RESP_OKAY, data: rd_first_q ? rdata_i : r_data_q};

	always_ff @(posedge s_6mhz_i or posedge reset)
	begin
		if (reset)
		begin
			arready_q   <= 1'b0;
			bvalid_q    <= 1'b0;
			rvalid_q    <= 1'b0;
			rd_first_q  <= 1'b0;
			req_valid_q <= 1'b0;
		end
		else
		begin
			// idle again only once nothing is left to hand back
			arready_q <= ~(aw_go | ar_hs | rd_req |
				(bvalid_q & ~bready_i) | (rvalid_q & ~rready_i));
			req_valid_q <= aw_go | ar_hs;
			rd_first_q  <= rd_req;
			// write response goes up with the request cycle
			if (aw_go)
				bvalid_q <= 1'b1;
			else if (bready_i)
				bvalid_q <= 1'b0;
			// read response follows the registered router byte
			if (rd_req)
				rvalid_q <= 1'b1;
			else if (rready_i)
				rvalid_q <= 1'b0;
		end
	end

	// request payload and read hold
	always_ff @(posedge s_6mhz_i)
	begin
		if (aw_go)
		begin
			req_write_q <= 1'b1;
			req_addr_q  <= aw_i.addr;
			req_wdata_q <= w_i.data;
		end
		else if (ar_hs)
		begin
			req_write_q <= 1'b0;
			req_addr_q  <= ar_i.addr;
		end
		if (rd_first_q)
			r_data_q <= rdata_i;
	end

	// a waiting write response holds and keeps both address channels closed
	a_b_hold: assert property (@(posedge s_6mhz_i) disable iff (reset)
		bvalid_q && !bready_i |=> bvalid_q && !awready_o && !arready_o);
	// read data does not move while stalled
	a_r_hold: assert property (@(posedge s_6mhz_i) disable iff (reset)
		rvalid_q && !rready_i |=> rvalid_q && $stable(r_o));

endmodule

// ==== rtl/io_bus_router.sv ====
// i/o address decode for the centipede board
// write pulses to the latch and earom, registered read byte back to the slave

`include "cent_defines.svh"

module io_bus_router
	import cent_bus_pkg::*;
	import cent_io_pkg::*;
(
	input  logic                     s_6mhz_i,
	input  logic                     reset,
	input  bus_req_t                 req_i,
	input  player_in_t               player_i,
	input  logic [`CENT_DATA_W-1:0]  joystick_i,
	input  logic [`CENT_DATA_W-1:0]  sw1_i,
	input  logic [`CENT_DATA_W-1:0]  sw2_i,
	input  logic                     vblank_i,
	input  trak_state_t              trak_i,
	input  logic [`CENT_DATA_W-1:0]  ea_data_i,
	output logic [`CENT_DATA_W-1:0]  rdata_o,
	output logic                     out_we_o,
	output logic [2:0]               out_idx_o,
	output logic                     out_bit_o,
	output logic                     ea_addr_we_o,
	output logic                     ea_ctrl_we_o,
	output logic [`CENT_EAROM_AW-1:0] ea_addr_o,
	output logic [`CENT_DATA_W-1:0]  ea_wdata_o
);

	io_region_e              region;
	logic                    wr;
	logic [`CENT_DATA_W-1:0] rd_byte;

	// ab[13:10] picks the block and the in and earom blocks split further down
	always_comb
	begin
		region = REG_NONE;
		case (req_i.addr[13:10])
			4'(`CENT_BLK_SW):  region = REG_SW;
			4'(`CENT_BLK_IN):  region = req_i.addr[1] ? REG_IN1 : REG_IN0;
			4'(`CENT_BLK_OUT): region = REG_OUT;
			4'(`CENT_BLK_EA):
			begin
				// earom parts only live in the upper half of the block
				if (req_i.addr[9])
				begin
					case (req_i.addr[8:7])
						2'd0:    region = REG_EA_RD;
						2'd1:    region = REG_EA_CTRL;
						2'd2:    region = REG_EA_ADDR;
						default: region = REG_NONE;
					endcase
				end
			end
			default: region = REG_NONE;
		endcase
	end

	assign wr = req_i.valid & req_i.write;

	// the latch takes ab[2:0] as index and d7 as value
	assign out_we_o     = wr & (region == REG_OUT);
	assign out_idx_o    = req_i.addr[2:0];
	assign out_bit_o    = req_i.wdata[7];
	assign ea_addr_we_o = wr & (region == REG_EA_ADDR);
	assign ea_ctrl_we_o = wr & (region == REG_EA_CTRL);
	assign ea_addr_o    = req_i.addr[`CENT_EAROM_AW-1:0];
	assign ea_wdata_o   = req_i.wdata;

	// ab[0] picks the half of each port in the read mux
	always_comb
	begin
		case (region)
			REG_IN0: rd_byte = req_i.addr[0] ?
				{player_i.coin_r, player_i.coin_c, player_i.coin_l, player_i.slam,
				 player_i.fire2, player_i.fire1, player_i.start2, player_i.start1} :
				{trak_i.h_dir, vblank_i, player_i.self_test, player_i.cocktail, trak_i.h_cnt};
			REG_IN1:   rd_byte = req_i.addr[0] ? joystick_i : {trak_i.v_dir, 3'b000, trak_i.v_cnt};
			REG_SW:    rd_byte = req_i.addr[0] ? sw2_i : sw1_i;
			REG_EA_RD: rd_byte = ea_data_i;
			// write only and unmapped regions read as zero
			default:   rd_byte = '0;
		endcase
	end

	always_ff @(posedge s_6mhz_i or posedge reset)
	begin
		if (reset)
			rdata_o <= '0;
		else
			rdata_o <= rd_byte;
	end

	// each write pulse lasts a single cycle and is never followed by another
	a_one_we: assert property (@(posedge s_6mhz_i) disable iff (reset)
		(out_we_o || ea_addr_we_o || ea_ctrl_we_o) |=>
		!(out_we_o || ea_addr_we_o || ea_ctrl_we_o));

endmodule

// ==== rtl/out_latch.sv ====
// addressable output latch, one bit per write
// drives screen flip, four lamps and three coin counters

module out_latch
	import cent_io_pkg::*;
(
	input  logic       s_6mhz_i,
	input  logic       reset,
	input  logic       we_i,
	input  logic [2:0] idx_i,
	input  logic       bit_i,
	output latch_out_t latch_o,
	output logic       flip_o
);

	logic [7:0] latch_q;

	// ab[2:0] picks the bit, d7 is the value written
	always_ff @(posedge s_6mhz_i or posedge reset)
	begin
		if (reset)
			latch_q <= '0;
		else if (we_i)
			latch_q[idx_i] <= bit_i;
	end

	// bit 7 flip, 6..3 lamps 4..1, 2..0 coin counters r/c/l
	assign latch_o = latch_out_t'(latch_q);

	// flip also picks which player's trackball gets read
	assign flip_o = latch_o.flip;

endmodule

// ==== rtl/trakball_counter.sv ====
// mini-trackball counters
// flip picks the player, each axis clock is synchronised and edge detected
// then counted up or down by its direction line

module trakball_counter
	import cent_io_pkg::*;
(
	input  logic        s_6mhz_i,
	input  logic        reset,
	input  trak_t       trak_i,
	input  logic        flip_i,
	output trak_state_t state_o
);

	// index 0 is the horizontal axis, 1 the vertical one
	logic [1:0]      ck_sel;
	logic [1:0]      dir_sel;
	logic [1:0]      ck_s1;
	logic [1:0]      ck_s2;
	logic [1:0]      ck_last;
	logic [1:0]      dir_s1;
	logic [1:0]      dir_s2;
	logic [1:0]      dir_q;
	logic [1:0][3:0] cnt_q;

	// flip high reads player 1, low reads player 2
	assign ck_sel  = flip_i ? {trak_i.p1_v_ck, trak_i.p1_h_ck} :
		{trak_i.p2_v_ck, trak_i.p2_h_ck};
	assign dir_sel = flip_i ? {trak_i.p1_v_dir, trak_i.p1_h_dir} :
		{trak_i.p2_v_dir, trak_i.p2_h_dir};

	always_ff @(posedge s_6mhz_i or posedge reset)
	begin
		if (reset)
		begin
			ck_s1   <= '0;
			ck_s2   <= '0;
			ck_last <= '0;
			dir_s1  <= '0;
			dir_s2  <= '0;
			dir_q   <= '0;
			cnt_q   <= '0;
		end
		else
		begin
			// two flop synchroniser, dir kept aligned with its clock
			ck_s1   <= ck_sel;
			ck_s2   <= ck_s1;
			ck_last <= ck_s2;
			dir_s1  <= dir_sel;
			dir_s2  <= dir_s1;
			// direction latch follows every cycle
			dir_q   <= dir_s2;
			for (int i = 0; i < 2; i++)
			begin
				// rising edge of the synced clock, dir 0 counts up
				if (ck_s2[i] & ~ck_last[i])
					cnt_q[i] <= dir_s2[i] ? cnt_q[i] - 4'd1 : cnt_q[i] + 4'd1;
			end
		end
	end

	assign state_o = '{h_dir: dir_q[0], v_dir: dir_q[1], h_cnt: cnt_q[0], v_cnt: cnt_q[1]};

endmodule

// ==== rtl/earom_store.sv ====
// 64 byte high score earom
// address/data latch, control register and the storage array

`include "cent_defines.svh"

module earom_store (
	input  logic                      s_6mhz_i,
	input  logic                      reset,
	input  logic                      addr_we_i,
	input  logic                      ctrl_we_i,
	input  logic [`CENT_EAROM_AW-1:0] addr_i,
	input  logic [`CENT_DATA_W-1:0]   wdata_i,
	output logic [`CENT_DATA_W-1:0]   rdata_o
);

	logic [`CENT_EAROM_AW-1:0] ea_addr_q;
	logic [`CENT_DATA_W-1:0]   ea_data_q;
	logic                      cs_q;
	logic                      erase_q;
	logic                      we_q;
	logic                      mem_we;
	logic [`CENT_DATA_W-1:0]   mem [2**`CENT_EAROM_AW];

	// address write grabs both ab[5:0] and the data byte
	always_ff @(posedge s_6mhz_i)
	begin
		if (addr_we_i)
		begin
			ea_addr_q <= addr_i;
			ea_data_q <= wdata_i;
		end
	end

	// control bits d3 chip select, d2 erase and d1 write enable
	// reset leaves the chip deselected in read mode
	always_ff @(posedge s_6mhz_i or posedge reset)
	begin
		if (reset)
		begin
			cs_q    <= 1'b0;
			erase_q <= 1'b0;
			we_q    <= 1'b0;
			rdata_o <= '0;
		end
		else
		begin
			if (ctrl_we_i)
			begin
				cs_q    <= wdata_i[3];
				erase_q <= wdata_i[2];
				we_q    <= wdata_i[1];
			end
			// read mode samples the array every cycle
			if (cs_q & ~we_q)
				rdata_o <= mem[ea_addr_q];
		end
	end

	// the array keeps writing for as long as write mode is held
	assign mem_we = cs_q & we_q;

	always_ff @(posedge s_6mhz_i)
	begin
		if (mem_we)
			mem[ea_addr_q] <= erase_q ? '0 : ea_data_q;
	end

	// stored byte at the latched address keeps its value while deselected
	a_no_wr_deselect: assert property (@(posedge s_6mhz_i) disable iff (reset)
		!cs_q && !addr_we_i |=> $stable(mem[ea_addr_q]));

endmodule

// ==== rtl/cent_io_top.sv ====
// centipede processor side i/o board
// axi4-lite in front of the decode, output latch, trackball and earom

`include "cent_defines.svh"

module cent_io_top
	import cent_bus_pkg::*;
	import cent_io_pkg::*;
(
	input  logic                    s_6mhz_i,
	input  logic                    reset,
	input  axil_aw_t                aw_i,
	input  logic                    awvalid_i,
	output logic                    awready_o,
	input  axil_w_t                 w_i,
	input  logic                    wvalid_i,
	output logic                    wready_o,
	output logic                    bvalid_o,
	input  logic                    bready_i,
	input  axil_ar_t                ar_i,
	input  logic                    arvalid_i,
	output logic                    arready_o,
	output logic                    rvalid_o,
	output axil_r_t                 r_o,
	input  logic                    rready_i,
	input  player_in_t              player_i,
	input  trak_t                   trak_i,
	input  logic [`CENT_DATA_W-1:0] joystick_i,
	input  logic [`CENT_DATA_W-1:0] sw1_i,
	input  logic [`CENT_DATA_W-1:0] sw2_i,
	input  logic                    vblank_i,
	output latch_out_t              latch_o
);

	bus_req_t                  req;
	logic [`CENT_DATA_W-1:0]   rdata;
	logic                      out_we;
	logic [2:0]                out_idx;
	logic                      out_bit;
	logic                      flip;
	logic                      ea_addr_we;
	logic                      ea_ctrl_we;
	logic [`CENT_EAROM_AW-1:0] ea_addr;
	logic [`CENT_DATA_W-1:0]   ea_wdata;
	logic [`CENT_DATA_W-1:0]   ea_rdata;
	trak_state_t               trak_state;

	axil_bus_slave u_axil_bus_slave (
		.s_6mhz_i (s_6mhz_i), .reset (reset),
		.aw_i (aw_i), .awvalid_i (awvalid_i), .awready_o (awready_o),
		.w_i (w_i), .wvalid_i (wvalid_i), .wready_o (wready_o),
		.bvalid_o (bvalid_o), .bready_i (bready_i),
		.ar_i (ar_i), .arvalid_i (arvalid_i), .arready_o (arready_o),
		.rvalid_o (rvalid_o), .r_o (r_o), .rready_i (rready_i),
		.rdata_i (rdata), .req_o (req)
	);

	io_bus_router u_io_bus_router (
		.s_6mhz_i (s_6mhz_i), .reset (reset), .req_i (req),
		.player_i (player_i), .joystick_i (joystick_i),
		.sw1_i (sw1_i), .sw2_i (sw2_i), .vblank_i (vblank_i),
		.trak_i (trak_state), .ea_data_i (ea_rdata), .rdata_o (rdata),
		.out_we_o (out_we), .out_idx_o (out_idx), .out_bit_o (out_bit),
		.ea_addr_we_o (ea_addr_we), .ea_ctrl_we_o (ea_ctrl_we),
		.ea_addr_o (ea_addr), .ea_wdata_o (ea_wdata)
	);

	out_latch u_out_latch (
		.s_6mhz_i (s_6mhz_i), .reset (reset), .we_i (out_we),
		.idx_i (out_idx), .bit_i (out_bit), .latch_o (latch_o), .flip_o (flip)
	);

	// flip from the latch steers the player select
	trakball_counter u_trakball_counter (
		.s_6mhz_i (s_6mhz_i), .reset (reset), .trak_i (trak_i),
		.flip_i (flip), .state_o (trak_state)
	);

	earom_store u_earom_store (
		.s_6mhz_i (s_6mhz_i), .reset (reset),
		.addr_we_i (ea_addr_we), .ctrl_we_i (ea_ctrl_we),
		.addr_i (ea_addr), .wdata_i (ea_wdata), .rdata_o (ea_rdata)
	);

endmodule

// ==== testbench/tb_cent_io_tasks.svh ====
// bus and compare tasks for the i/o board testbench
// axi4-lite master side with bounded waits and typed result checks

`ifndef TB_CENT_IO_TASKS_SVH
`define TB_CENT_IO_TASKS_SVH

// a wait ran out of cycles
task automatic stop_on_timeout(input string what);
	$display("timeout while waiting for %s", what);
	$display("=== FAIL ===");
	$fatal(1, "simulation stopped after a timeout");
endtask

// wrong value seen on a dut output
task automatic stop_on_mismatch(input string name, input logic [15:0] got,
	input logic [15:0] exp);
	$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
	$display("=== FAIL ===");
	$fatal(1, "simulation stopped at the first mismatch");
endtask

task automatic check_byte(input string name, input logic [`CENT_DATA_W-1:0] got,
	input logic [`CENT_DATA_W-1:0] exp);
	if (got !== exp)
		stop_on_mismatch(name, {8'h00, got}, {8'h00, exp});
endtask

task automatic check_latch(input string name, input latch_out_t got, input latch_out_t exp);
	if (got !== exp)
		stop_on_mismatch(name, {8'h00, got}, {8'h00, exp});
endtask

task automatic check_resp(input string name, input axil_r_t got);
	if (got.resp !== AXIL_RESP_OKAY)
		stop_on_mismatch(name, {14'h0, got.resp}, {14'h0, AXIL_RESP_OKAY});
endtask

// one write with bready held low for stall cycles after the handshake
task automatic axi_write(input logic [`CENT_ADDR_W-1:0] addr,
	input logic [`CENT_DATA_W-1:0] data, input int stall);
	int n;
	@(posedge s_6mhz);
	aw        <= '{addr: addr};
	w         <= '{data: data};
	awvalid   <= 1'b1;
	wvalid    <= 1'b1;
	bready    <= (stall == 0);
	n = 0;
	do
	begin
		@(posedge s_6mhz);
		n++;
		if (n > TMO)
			stop_on_timeout("awready");
	end
	while (!awready);
	// wready has to come up together with awready
	if (wready !== 1'b1)
		stop_on_mismatch("wready", {15'h0, wready}, 16'h0001);
	awvalid <= 1'b0;
	wvalid  <= 1'b0;
	n = 0;
	while (!(bvalid && bready))
	begin
		if (n >= stall)
			bready <= 1'b1;
		@(posedge s_6mhz);
		n++;
		if (n > TMO)
			stop_on_timeout("write response");
	end
	bready <= 1'b0;
endtask

// one read with the data taken at the rvalid/rready edge
task automatic axi_read(input logic [`CENT_ADDR_W-1:0] addr, input int stall,
	output logic [`CENT_DATA_W-1:0] data);
	int      n;
	axil_r_t r;
	@(posedge s_6mhz);
	ar      <= '{addr: addr};
	arvalid <= 1'b1;
	rready  <= (stall == 0);
	n = 0;
	do
	begin
		@(posedge s_6mhz);
		n++;
		if (n > TMO)
			stop_on_timeout("arready");
	end
	while (!arready);
	arvalid <= 1'b0;
	n = 0;
	while (!(rvalid && rready))
	begin
		if (n >= stall)
			rready <= 1'b1;
		@(posedge s_6mhz);
		n++;
		if (n > TMO)
			stop_on_timeout("read data");
	end
	r = r_o;
	rready <= 1'b0;
	check_resp("rresp", r);
	data = r.data;
endtask

`endif

// ==== testbench/tb_cent_io.sv ====
// testbench for the centipede i/o board
// table driven axi4-lite traffic followed by trackball counting through the read ports

`include "cent_defines.svh"

module tb_cent_io
	import cent_bus_pkg::*;
	import cent_io_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TMO = 200;

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_LATCH, OP_SET} op_e;

	// one table row whose input fields only matter for OP_SET
	typedef struct packed {
		op_e                     op;
		logic [`CENT_ADDR_W-1:0] addr;
		logic [`CENT_DATA_W-1:0] data;
		logic [`CENT_DATA_W-1:0] exp;
		latch_out_t              exp_latch;
		player_in_t              player;
		logic [7:0]              joy;
		logic [7:0]              sw1;
		logic [7:0]              sw2;
		logic                    vbl;
	} step_t;

	logic       s_6mhz;
	logic       reset;
	axil_aw_t   aw;
	logic       awvalid;
	logic       awready;
	axil_w_t    w;
	logic       wvalid;
	logic       wready;
	logic       bvalid;
	logic       bready;
	axil_ar_t   ar;
	logic       arvalid;
	logic       arready;
	logic       rvalid;
	axil_r_t    r_o;
	logic       rready;
	player_in_t player;
	trak_t      trak;
	logic [7:0] joystick;
	logic [7:0] sw1;
	logic [7:0] sw2;
	logic       vblank;
	latch_out_t latch;

	int         seed;
	step_t      steps[$];
	// expected latch contents with bit n set by a write to 0x1c00 + n
	logic [7:0] latch_model;

	cent_io_top u_cent_io_top (
		.s_6mhz_i (s_6mhz), .reset (reset),
		.aw_i (aw), .awvalid_i (awvalid), .awready_o (awready),
		.w_i (w), .wvalid_i (wvalid), .wready_o (wready),
		.bvalid_o (bvalid), .bready_i (bready),
		.ar_i (ar), .arvalid_i (arvalid), .arready_o (arready),
		.rvalid_o (rvalid), .r_o (r_o), .rready_i (rready),
		.player_i (player), .trak_i (trak), .joystick_i (joystick),
		.sw1_i (sw1), .sw2_i (sw2), .vblank_i (vblank), .latch_o (latch)
	);

	always #5 s_6mhz = ~s_6mhz;

	`include "tb_cent_io_tasks.svh"

	function automatic int rand_stall();
		return int'($unsigned($random(seed)) % 4);
	endfunction

	task automatic add_wr(input logic [13:0] addr, input logic [7:0] data);
		step_t s;
		s = '0;
		s.op   = OP_WR;
		s.addr = addr;
		s.data = data;
		if (addr[13:3] == 11'(14'h1c00 >> 3))
			latch_model[addr[2:0]] = data[7];
		steps.push_back(s);
	endtask

	task automatic add_rd(input logic [13:0] addr, input logic [7:0] exp);
		step_t s;
		s = '0;
		s.op   = OP_RD;
		s.addr = addr;
		s.exp  = exp;
		steps.push_back(s);
	endtask

	task automatic add_latch();
		step_t s;
		s = '0;
		s.op        = OP_LATCH;
		s.exp_latch = latch_out_t'(latch_model);
		steps.push_back(s);
	endtask

	// trackball clock pulses on one axis where 0 is p2 horizontal and 1 is p1 vertical
	task automatic spin(input int axis, input logic dir, input int n);
		if (axis == 0)
			trak.p2_h_dir <= dir;
		else
			trak.p1_v_dir <= dir;
		repeat (4) @(posedge s_6mhz);
		for (int i = 0; i < n; i++)
		begin
			@(posedge s_6mhz);
			if (axis == 0)
				trak.p2_h_ck <= 1'b1;
			else
				trak.p1_v_ck <= 1'b1;
			repeat (2) @(posedge s_6mhz);
			if (axis == 0)
				trak.p2_h_ck <= 1'b0;
			else
				trak.p1_v_ck <= 1'b0;
			@(posedge s_6mhz);
		end
	endtask

	// poll a port until its count nibble settles and then check the whole byte
	task automatic wait_count(input logic [13:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		int         n;
		n = 0;
		axi_read(addr, 0, got);
		while (got[3:0] !== exp[3:0])
		begin
			n++;
			if (n > 20)
				stop_on_timeout("trackball count");
			axi_read(addr, 0, got);
		end
		check_byte($sformatf("rdata@%h", addr), got, exp);
	endtask

	initial
	begin
		step_t      s;
		player_in_t p;
		logic [7:0] j;
		logic [7:0] b1;
		logic [7:0] b2;
		logic       v;
		logic [5:0] ea;
		logic [7:0] ed;
		logic [7:0] got;
		logic [3:0] h_cnt;
		int         n;

		seed        = 32'hfd02_ac06;
		latch_model = '0;
		s_6mhz      = 1'b0;
		reset       = 1'b1;
		aw          = '0;
		awvalid     = 1'b0;
		w           = '0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		ar          = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		player      = '0;
		trak        = '0;
		joystick    = '0;
		sw1         = '0;
		sw2         = '0;
		vblank      = 1'b0;

		// after reset the latch is clear and the vertical port empty
		add_latch();
		add_rd(14'h0c02, 8'h00);

		// random inputs read back through every port half
		p  = player_in_t'($random(seed));
		j  = 8'($random(seed));
		b1 = 8'($random(seed));
		b2 = 8'($random(seed));
		v  = 1'($random(seed));
		s = '0;
		s.op     = OP_SET;
		s.player = p;
		s.joy    = j;
		s.sw1    = b1;
		s.sw2    = b2;
		s.vbl    = v;
		steps.push_back(s);
		add_rd(14'h0c00, {1'b0, v, p.self_test, p.cocktail, 4'h0});
		add_rd(14'h0c01, {p.coin_r, p.coin_c, p.coin_l, p.slam,
			p.fire2, p.fire1, p.start2, p.start1});
		add_rd(14'h0c03, j);
		add_rd(14'h0c02, 8'h00);
		add_rd(14'h0800, b1);
		add_rd(14'h0801, b2);
		// nothing lives here or in the lower half of the earom block
		add_rd(14'h0400, 8'h00);
		add_rd(14'h1400, 8'h00);

		// random d7 per latch bit and then everything cleared
		for (int i = 0; i < 8; i++)
		begin
			add_wr(14'h1c00 + 14'(i), 8'($random(seed)));
			add_latch();
		end
		for (int i = 0; i < 8; i++)
			add_wr(14'h1c00 + 14'(i), 8'h00);
		add_latch();

		// earom write then erase of one byte
		ea = 6'($random(seed));
		ed = 8'($random(seed)) | 8'h01;
		add_wr(14'h1700 | 14'(ea), ed);
		add_wr(14'h1680, 8'h0a);
		add_wr(14'h1680, 8'h08);
		add_rd(14'h1600, ed);
		add_wr(14'h1680, 8'h0e);
		add_wr(14'h1680, 8'h08);
		add_rd(14'h1600, 8'h00);

		repeat (2) @(posedge s_6mhz);
		reset <= 1'b0;

		foreach (steps[k])
		begin
			s = steps[k];
			case (s.op)
				OP_WR:
					axi_write(s.addr, s.data, rand_stall());
				OP_RD:
				begin
					axi_read(s.addr, rand_stall(), got);
					check_byte($sformatf("rdata@%h", s.addr), got, s.exp);
				end
				OP_LATCH:
				begin
					repeat (2) @(posedge s_6mhz);
					check_latch("latch_o", latch, s.exp_latch);
				end
				default:
				begin
					@(posedge s_6mhz);
					player   <= s.player;
					joystick <= s.joy;
					sw1      <= s.sw1;
					sw2      <= s.sw2;
					vblank   <= s.vbl;
					@(posedge s_6mhz);
				end
			endcase
		end

		// with flip clear player 2 horizontal counts up and then down
		n     = 5 + int'($unsigned($random(seed)) % 16);
		h_cnt = 4'(n);
		spin(0, 1'b0, n);
		wait_count(14'h0c00, {1'b0, vblank, player.self_test, player.cocktail, h_cnt});
		h_cnt = h_cnt - 4'd3;
		spin(0, 1'b1, 3);
		wait_count(14'h0c00, {1'b1, vblank, player.self_test, player.cocktail, h_cnt});

		// with flip set player 1 vertical drives the counter
		axi_write(14'h1c07, 8'h80, 0);
		n = 1 + int'($unsigned($random(seed)) % 12);
		spin(1, 1'b0, n);
		wait_count(14'h0c02, {4'h0, 4'(n)});

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+rtl
+incdir+testbench
rtl/cent_bus_pkg.sv
rtl/cent_io_pkg.sv
rtl/axil_bus_slave.sv
rtl/io_bus_router.sv
rtl/out_latch.sv
rtl/trakball_counter.sv
rtl/earom_store.sv
rtl/cent_io_top.sv
testbench/tb_cent_io.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the i/o board testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_cent_io \
	-o sim_cent_io > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/sim_cent_io > sim.log 2>&1
status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulator returned status $status"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "no pass line in the log"
	exit 1
fi
exit 0
